/* dv/program_input.txt */
# B boot | I program word, consecutive from boot | E expected retirement: pc rd data
# All values hex. Text after # is ignored.
B 00000100
I 00500093  # 100 addi x1, x0, 5
I 00708113  # 104 addi x2, x1, 7
I 002081b3  # 108 add  x3, x1, x2
I 40208233  # 10c sub  x4, x1, x2
I 0021e2b3  # 110 or   x5, x3, x2
I 0011c333  # 114 xor  x6, x3, x1
I 001223b3  # 118 slt  x7, x4, x1
I 0040a433  # 11c slt  x8, x1, x4
I 123454b7  # 120 lui  x9, 0x12345
I 6784e493  # 124 ori  x9, x9, 0x678
I 0f04f513  # 128 andi x10, x9, 0xf0
I fff54593  # 12c xori x11, x10, -1
I 00908013  # 130 addi x0, x1, 9
I 00100633  # 134 add  x12, x0, x1
I 00408463  # 138 beq  x1, x4, +8   not taken
I 00c09463  # 13c bne  x1, x12, +8  not taken
I 00c08663  # 140 beq  x1, x12, +12 taken
I 00100613  # 144 addi x12, x0, 1   killed
I 00200613  # 148 addi x12, x0, 2   killed
I 00219663  # 14c bne  x3, x2, +12  taken
I 00300193  # 150 addi x3, x0, 3    killed
I 00400193  # 154 addi x3, x0, 4    killed
I 0061f7b3  # 158 and  x15, x3, x6
I 00c78833  # 15c add  x16, x15, x12
I 00000063  # 160 beq  x0, x0, 0
E 00000100 01 00000005
E 00000104 02 0000000c
E 00000108 03 00000011
E 0000010c 04 fffffff9
E 00000110 05 0000001d
E 00000114 06 00000014
E 00000118 07 00000001
E 0000011c 08 00000000
E 00000120 09 12345000
E 00000124 09 12345678
E 00000128 0a 00000070
E 0000012c 0b ffffff8f
E 00000130 00 00000000
E 00000134 0c 00000005
E 00000138 00 00000000
E 0000013c 00 00000000
E 00000140 00 00000000
E 0000014c 00 00000000
E 00000158 0f 00000010
E 0000015c 10 00000015
E 00000160 00 00000000
E 00000160 00 00000000

/* src.f */
rtl/riscv_isa_pkg.sv
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/control_unit.sv
rtl/riscv_core.sv
dv/riscv_core_tb.sv

/* dv/riscv_core_tb.sv */
/*
 * Testbench of the RV32I core. Loads the boot address, the program and the
 * expected retirement trace from dv/program_input.txt, serves instruction
 * fetches with a random latency and compares each retirement with the trace.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb;

  localparam int MAX_LAT   = 3;   // Worst case memory latency in cycles
  localparam int MAX_WORDS = 64;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [31:0] boot_addr_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic [31:0] retire_insn_o;
  logic [4:0]  retire_rd_addr_o;
  logic [31:0] retire_rd_wdata_o;

  logic [31:0] prog_mem [0:MAX_WORDS-1];
  logic [31:0] exp_pc   [0:MAX_WORDS-1];
  logic [4:0]  exp_rd   [0:MAX_WORDS-1];
  logic [31:0] exp_data [0:MAX_WORDS-1];
  int          num_words;
  int          num_exp;
  int          exp_idx;
  int          checks;
  int          errors;
  int          reset_cycles;
  int          wait_cycles;
  integer      seed;
  bit          loaded;
  bit          done;
  bit          first_req;
  bit          pending;
  logic [31:0] pending_addr;

  riscv_core dut (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .boot_addr_i       ( boot_addr_i       ),
    .instr_rvalid_i    ( instr_rvalid_i    ),
    .instr_rdata_i     ( instr_rdata_i     ),
    .instr_req_o       ( instr_req_o       ),
    .instr_addr_o      ( instr_addr_o      ),
    .retire_valid_o    ( retire_valid_o    ),
    .retire_pc_o       ( retire_pc_o       ),
    .retire_insn_o     ( retire_insn_o     ),
    .retire_rd_addr_o  ( retire_rd_addr_o  ),
    .retire_rd_wdata_o ( retire_rd_wdata_o )
  );

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - boot_addr_i;
    if (addr >= boot_addr_i && (offset >> 2) < num_words) return prog_mem[offset >> 2];
    return addr ^ 32'h5a5a_5a5a;  // Outside the program, only fetched past a branch
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    errors++;
  endtask

  // Reads the B, I and E lines and skips text after a #
  task automatic load_program(output bit ok);
    integer      fd;
    integer      c;
    integer      n;
    bit          well_formed;
    logic [31:0] v0, v1, v2;
    ok          = 1'b0;
    well_formed = 1'b1;
    fd = $fopen("dv/program_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open dv/program_input.txt");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while (c != "\n" && c != -1) c = $fgetc(fd);
        end else if (c == "B") begin
          n = $fscanf(fd, "%h", boot_addr_i);
          if (n != 1) well_formed = 1'b0;
        end else if (c == "I") begin
          n = $fscanf(fd, "%h", v0);
          if (n != 1 || num_words == MAX_WORDS) begin
            well_formed = 1'b0;
          end else begin
            prog_mem[num_words] = v0;
            num_words++;
          end
        end else if (c == "E") begin
          n = $fscanf(fd, "%h %h %h", v0, v1, v2);
          if (n != 3 || num_exp == MAX_WORDS) begin
            well_formed = 1'b0;
          end else begin
            exp_pc[num_exp]   = v0;
            exp_rd[num_exp]   = v1[4:0];
            exp_data[num_exp] = v2;
            num_exp++;
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
      if (!well_formed) $display("ERROR: malformed or excess line in dv/program_input.txt");
      ok = well_formed && (num_words > 0) && (num_exp > 0);
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  task automatic take_request();
    if (instr_req_o === 1'b1) begin
      if (pending) begin
        $display("ERROR: instruction request to %h while a response is pending",
                 instr_addr_o);
        errors++;
      end
      if (first_req) begin
        checks++;
        if (instr_addr_o !== boot_addr_i)
          report_mismatch("boot address", boot_addr_i, instr_addr_o);
        first_req = 1'b0;
      end
      pending      = 1'b1;
      pending_addr = instr_addr_o;
      wait_cycles  = 1 + ($unsigned($random(seed)) % MAX_LAT);
    end
  endtask

  task automatic drive_response();
    instr_rvalid_i = 1'b0;
    if (pending) begin
      wait_cycles--;
      if (wait_cycles == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = word_at(pending_addr);
        pending        = 1'b0;
      end
    end
  endtask

  task automatic expect_idle_in_reset();
    checks += 2;
    if (retire_valid_o !== 1'b0) begin
      $display("ERROR: retirement reported while reset is asserted");
      errors++;
    end
    if (instr_req_o !== 1'b0) begin
      $display("ERROR: instruction request issued while reset is asserted");
      errors++;
    end
  endtask

  task automatic check_retirement();
    string name;
    if (retire_valid_o === 1'b1 && !done) begin
      name = $sformatf("retire %0d at %h", exp_idx, exp_pc[exp_idx]);
      checks += 4;
      if (retire_pc_o !== exp_pc[exp_idx])
        report_mismatch({name, " pc"}, exp_pc[exp_idx], retire_pc_o);
      if (retire_insn_o !== word_at(exp_pc[exp_idx]))
        report_mismatch({name, " insn"}, word_at(exp_pc[exp_idx]), retire_insn_o);
      if (retire_rd_addr_o !== exp_rd[exp_idx])
        report_mismatch({name, " rd"}, {27'b0, exp_rd[exp_idx]}, {27'b0, retire_rd_addr_o});
      if (retire_rd_wdata_o !== exp_data[exp_idx])
        report_mismatch({name, " data"}, exp_data[exp_idx], retire_rd_wdata_o);
      exp_idx++;
      if (exp_idx == num_exp) done = 1'b1;
    end
  endtask

  // Inputs change on the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      expect_idle_in_reset();
      reset_cycles++;
      if (reset_cycles == 2) rst_i = 1'b0;
    end else if (loaded) begin
      drive_response();
    end
  end

  // Outputs are taken on the rising edge where the DUT samples too
  always @(posedge clk_i) begin
    if (!rst_i && loaded) begin
      take_request();
      check_retirement();
    end
  end

  ////////////////////
  // Run control
  ////////////////////

  initial begin
    bit ok;
    rst_i          = 1'b1;
    boot_addr_i    = '0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    seed           = 74;
    first_req      = 1'b1;
    load_program(ok);
    if (!ok) begin
      $display("ERROR: no usable program or expected trace in dv/program_input.txt");
      $display("Summary: %0d checks, %0d errors", checks, errors + 1);
      $display("Test failed");
      $finish;
    end else begin
      loaded = 1'b1;
      wait (done);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // Watchdog scaled by the length of the trace
  initial begin
    wait (loaded);
    repeat (num_exp * 20 + 100) @(posedge clk_i);
    $display("ERROR: timeout with %0d of %0d retirements seen", exp_idx, num_exp);
    $display("Summary: %0d checks, %0d errors", checks, errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/riscv_core.sv */
/*
 * Top level of the RV32I integer pipeline. Connects fetch, decode, execute
 * and the control unit to the instruction port and the retirement trace.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       boot_addr_i,
  input  logic                                 instr_rvalid_i,
  input  logic [riscv_isa_pkg::ILEN-1:0]       instr_rdata_i,
  output logic                                 instr_req_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       instr_addr_o,
  output logic                                 retire_valid_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       retire_pc_o,
  output logic [riscv_isa_pkg::ILEN-1:0]       retire_insn_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] retire_rd_addr_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       retire_rd_wdata_o
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic                  f_valid;
  logic [ILEN-1:0]       f_instr;
  logic [XLEN-1:0]       f_pc;

  logic [REG_ADDR_W-1:0] d_rs1_addr, d_rs2_addr, d_rd_addr;
  logic                  d_rs1_used, d_rs2_used;
  logic                  d_valid, d_rd_we, d_branch, d_branch_ne;
  logic [XLEN-1:0]       d_pc, d_op1, d_op2, d_target_pc;
  logic [ILEN-1:0]       d_instr;
  alu_op_e               d_alu_op;

  logic                  branch_taken;
  logic [XLEN-1:0]       branch_target;
  logic                  w_rd_we;
  logic [REG_ADDR_W-1:0] w_rd_addr;
  logic [XLEN-1:0]       w_rd_wdata;

  logic                  stall_f, stall_d, kill_f, kill_d, force_pc_valid;
  logic [XLEN-1:0]       force_pc;

  fetch_stage i_fetch_stage (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .boot_addr_i      ( boot_addr_i    ),
    .instr_rvalid_i   ( instr_rvalid_i ),
    .instr_rdata_i    ( instr_rdata_i  ),
    .stall_i          ( stall_f        ),
    .kill_i           ( kill_f         ),
    .force_pc_valid_i ( force_pc_valid ),
    .force_pc_i       ( force_pc       ),
    .instr_req_o      ( instr_req_o    ),
    .instr_addr_o     ( instr_addr_o   ),
    .f_valid_o        ( f_valid        ),
    .f_instr_o        ( f_instr        ),
    .f_pc_o           ( f_pc           )
  );

  decode_stage i_decode_stage (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .f_valid_i     ( f_valid     ),
    .f_instr_i     ( f_instr     ),
    .f_pc_i        ( f_pc        ),
    .stall_i       ( stall_d     ),
    .kill_i        ( kill_d      ),
    .w_rd_we_i     ( w_rd_we     ),
    .w_rd_addr_i   ( w_rd_addr   ),
    .w_rd_wdata_i  ( w_rd_wdata  ),
    .d_rs1_addr_o  ( d_rs1_addr  ),
    .d_rs1_used_o  ( d_rs1_used  ),
    .d_rs2_addr_o  ( d_rs2_addr  ),
    .d_rs2_used_o  ( d_rs2_used  ),
    .d_valid_o     ( d_valid     ),
    .d_pc_o        ( d_pc        ),
    .d_instr_o     ( d_instr     ),
    .d_op1_o       ( d_op1       ),
    .d_op2_o       ( d_op2       ),
    .d_alu_op_o    ( d_alu_op    ),
    .d_rd_addr_o   ( d_rd_addr   ),
    .d_rd_we_o     ( d_rd_we     ),
    .d_branch_o    ( d_branch    ),
    .d_branch_ne_o ( d_branch_ne ),
    .d_target_pc_o ( d_target_pc )
  );

  execute_stage i_execute_stage (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .d_valid_i         ( d_valid           ),
    .d_pc_i            ( d_pc              ),
    .d_instr_i         ( d_instr           ),
    .d_op1_i           ( d_op1             ),
    .d_op2_i           ( d_op2             ),
    .d_alu_op_i        ( d_alu_op          ),
    .d_rd_addr_i       ( d_rd_addr         ),
    .d_rd_we_i         ( d_rd_we           ),
    .d_branch_i        ( d_branch          ),
    .d_branch_ne_i     ( d_branch_ne       ),
    .d_target_pc_i     ( d_target_pc       ),
    .branch_taken_o    ( branch_taken      ),
    .branch_target_o   ( branch_target     ),
    .w_rd_we_o         ( w_rd_we           ),
    .w_rd_addr_o       ( w_rd_addr         ),
    .w_rd_wdata_o      ( w_rd_wdata        ),
    .retire_valid_o    ( retire_valid_o    ),
    .retire_pc_o       ( retire_pc_o       ),
    .retire_insn_o     ( retire_insn_o     ),
    .retire_rd_addr_o  ( retire_rd_addr_o  ),
    .retire_rd_wdata_o ( retire_rd_wdata_o )
  );

  // The decode register is the instruction now in execute
  control_unit i_control_unit (
    .d_rs1_addr_i     ( d_rs1_addr     ),
    .d_rs1_used_i     ( d_rs1_used     ),
    .d_rs2_addr_i     ( d_rs2_addr     ),
    .d_rs2_used_i     ( d_rs2_used     ),
    .e_valid_i        ( d_valid        ),
    .e_rd_we_i        ( d_rd_we        ),
    .e_rd_addr_i      ( d_rd_addr      ),
    .branch_taken_i   ( branch_taken   ),
    .branch_target_i  ( branch_target  ),
    .stall_f_o        ( stall_f        ),
    .stall_d_o        ( stall_d        ),
    .kill_f_o         ( kill_f         ),
    .kill_d_o         ( kill_d         ),
    .force_pc_valid_o ( force_pc_valid ),
    .force_pc_o       ( force_pc       )
  );

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
/*
 * Pipeline control. Stalls fetch and decode on a read-after-write hazard
 * against the instruction in execute, and on a taken branch kills the two
 * younger stages and redirects fetch.
 */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] d_rs1_addr_i,
  input  logic                                 d_rs1_used_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] d_rs2_addr_i,
  input  logic                                 d_rs2_used_i,
  input  logic                                 e_valid_i,
  input  logic                                 e_rd_we_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] e_rd_addr_i,
  input  logic                                 branch_taken_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       branch_target_i,
  output logic                                 stall_f_o,
  output logic                                 stall_d_o,
  output logic                                 kill_f_o,
  output logic                                 kill_d_o,
  output logic                                 force_pc_valid_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       force_pc_o
);

  logic rs1_hazard, rs2_hazard, hazard;

  // x0 never carries a dependency
  assign rs1_hazard = d_rs1_used_i && (d_rs1_addr_i != '0) && (d_rs1_addr_i == e_rd_addr_i);
  assign rs2_hazard = d_rs2_used_i && (d_rs2_addr_i != '0) && (d_rs2_addr_i == e_rd_addr_i);
  assign hazard     = e_valid_i && e_rd_we_i && (rs1_hazard || rs2_hazard);

  assign stall_f_o = hazard && !branch_taken_i;  // Kill wins
  assign stall_d_o = hazard && !branch_taken_i;

  assign kill_f_o         = branch_taken_i;
  assign kill_d_o         = branch_taken_i;
  assign force_pc_valid_o = branch_taken_i;
  assign force_pc_o       = branch_target_i;

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
/*
 * Execute stage. Runs the ALU, resolves branches against the operands and
 * registers the result into the writeback register, which both writes the
 * register file and presents the retirement trace.
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 d_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       d_pc_i,
  input  logic [riscv_isa_pkg::ILEN-1:0]       d_instr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       d_op1_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       d_op2_i,
  input  core_pkg::alu_op_e                    d_alu_op_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] d_rd_addr_i,
  input  logic                                 d_rd_we_i,
  input  logic                                 d_branch_i,
  input  logic                                 d_branch_ne_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       d_target_pc_i,
  output logic                                 branch_taken_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       branch_target_o,
  output logic                                 w_rd_we_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] w_rd_addr_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       w_rd_wdata_o,
  output logic                                 retire_valid_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       retire_pc_o,
  output logic [riscv_isa_pkg::ILEN-1:0]       retire_insn_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] retire_rd_addr_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       retire_rd_wdata_o
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [XLEN-1:0]       alu_result;
  logic                  rd_write;
  logic [REG_ADDR_W-1:0] rd_addr_q;
  logic [XLEN-1:0]       rd_wdata_q;

  always_comb begin
    case (d_alu_op_i)
      ALU_SUB:    alu_result = d_op1_i - d_op2_i;
      ALU_AND:    alu_result = d_op1_i & d_op2_i;
      ALU_OR:     alu_result = d_op1_i | d_op2_i;
      ALU_XOR:    alu_result = d_op1_i ^ d_op2_i;
      ALU_SLT:    alu_result = {31'b0, $signed(d_op1_i) < $signed(d_op2_i)};
      ALU_PASS_B: alu_result = d_op2_i;
      default:    alu_result = d_op1_i + d_op2_i;
    endcase
  end

  // BEQ on equal, BNE on not equal
  assign branch_taken_o  = d_valid_i && d_branch_i && ((d_op1_i == d_op2_i) != d_branch_ne_i);
  assign branch_target_o = d_target_pc_i;

  assign rd_write = d_rd_we_i && (d_rd_addr_i != '0);  // x0 stays zero

  ////////////////////
  // Writeback register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_valid_o <= 1'b0;
      w_rd_we_o      <= 1'b0;
    end else begin
      retire_valid_o <= d_valid_i;
      w_rd_we_o      <= d_valid_i && rd_write;
    end
  end

  always_ff @(posedge clk_i) begin
    retire_pc_o   <= d_pc_i;
    retire_insn_o <= d_instr_i;
    rd_addr_q     <= rd_write ? d_rd_addr_i : '0;
    rd_wdata_q    <= rd_write ? alu_result : '0;
  end

  assign w_rd_addr_o       = rd_addr_q;
  assign w_rd_wdata_o      = rd_wdata_q;
  assign retire_rd_addr_o  = rd_addr_q;
  assign retire_rd_wdata_o = rd_wdata_q;

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
/*
 * Decode stage. Decodes the instruction in the fetch register, reads the
 * register file and fills the decode register. The register file is written
 * from the writeback register, with the new value visible to a same-cycle read.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 f_valid_i,
  input  logic [riscv_isa_pkg::ILEN-1:0]       f_instr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       f_pc_i,
  input  logic                                 stall_i,
  input  logic                                 kill_i,
  input  logic                                 w_rd_we_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] w_rd_addr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       w_rd_wdata_i,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] d_rs1_addr_o,
  output logic                                 d_rs1_used_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] d_rs2_addr_o,
  output logic                                 d_rs2_used_o,
  output logic                                 d_valid_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       d_pc_o,
  output logic [riscv_isa_pkg::ILEN-1:0]       d_instr_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       d_op1_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       d_op2_o,
  output core_pkg::alu_op_e                    d_alu_op_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] d_rd_addr_o,
  output logic                                 d_rd_we_o,
  output logic                                 d_branch_o,
  output logic                                 d_branch_ne_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       d_target_pc_o
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i, imm_u, imm_b;
  logic [XLEN-1:0] rs1_data, rs2_data, op2;
  alu_op_e         alu_op;
  logic            rs1_used, rs2_used, rd_we, branch;
  logic            load_d;
  logic [XLEN-1:0] regs [1:31];

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub);
    case (f3)
      F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
      F3_SLT:     return ALU_SLT;
      F3_XOR:     return ALU_XOR;
      F3_OR:      return ALU_OR;
      F3_AND:     return ALU_AND;
      default:    return ALU_ADD;
    endcase
  endfunction

  assign funct3       = f_instr_i[14:12];
  assign d_rs1_addr_o = f_instr_i[19:15];
  assign d_rs2_addr_o = f_instr_i[24:20];
  assign d_rs1_used_o = f_valid_i && rs1_used;
  assign d_rs2_used_o = f_valid_i && rs2_used;

  assign imm_i = {{20{f_instr_i[31]}}, f_instr_i[31:20]};
  assign imm_u = {f_instr_i[31:12], 12'b0};
  assign imm_b = {{20{f_instr_i[31]}}, f_instr_i[7], f_instr_i[30:25], f_instr_i[11:8], 1'b0};

  always_comb begin
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    rd_we    = 1'b0;
    branch   = 1'b0;
    alu_op   = ALU_ADD;
    op2      = imm_i;
    case (opcode_e'(f_instr_i[6:0]))
      OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        rd_we    = 1'b1;
        op2      = rs2_data;
        alu_op   = alu_from_f3(funct3, f_instr_i[31:25] == F7_SUB);
      end
      OPC_OP_IMM: begin
        rs1_used = 1'b1;
        rd_we    = 1'b1;
        alu_op   = alu_from_f3(funct3, 1'b0);
      end
      OPC_LUI: begin
        rd_we  = 1'b1;
        op2    = imm_u;
        alu_op = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        op2      = rs2_data;
        branch   = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
      end
      default: ;  // Retires without effect
    endcase
  end

  ////////////////////
  // Register file
  ////////////////////

  assign rs1_data = (d_rs1_addr_o == '0) ? '0 :
                    (w_rd_we_i && w_rd_addr_i == d_rs1_addr_o) ? w_rd_wdata_i :
                    regs[d_rs1_addr_o];
  assign rs2_data = (d_rs2_addr_o == '0) ? '0 :
                    (w_rd_we_i && w_rd_addr_i == d_rs2_addr_o) ? w_rd_wdata_i :
                    regs[d_rs2_addr_o];

  always_ff @(posedge clk_i) begin
    if (w_rd_we_i && w_rd_addr_i != '0) regs[w_rd_addr_i] <= w_rd_wdata_i;
  end

  ////////////////////
  // Decode register
  ////////////////////

  assign load_d = f_valid_i && !stall_i && !kill_i;  // Otherwise a bubble

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      d_valid_o  <= 1'b0;
      d_rd_we_o  <= 1'b0;
      d_branch_o <= 1'b0;
    end else begin
      d_valid_o  <= load_d;
      d_rd_we_o  <= load_d && rd_we;
      d_branch_o <= load_d && branch;
    end
  end

  always_ff @(posedge clk_i) begin
    d_pc_o        <= f_pc_i;
    d_instr_o     <= load_d ? f_instr_i : INSN_NOP;
    d_op1_o       <= rs1_data;
    d_op2_o       <= op2;
    d_alu_op_o    <= alu_op;
    d_rd_addr_o   <= f_instr_i[11:7];
    d_branch_ne_o <= (funct3 == F3_BNE);
    d_target_pc_o <= f_pc_i + imm_b;
  end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
/*
 * Fetch stage. Keeps the PC, issues one instruction request at a time and
 * captures the response into the fetch register. A kill while a request is
 * pending lets the stale response pass by unused.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] boot_addr_i,
  input  logic                           instr_rvalid_i,
  input  logic [riscv_isa_pkg::ILEN-1:0] instr_rdata_i,
  input  logic                           stall_i,
  input  logic                           kill_i,
  input  logic                           force_pc_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] force_pc_i,
  output logic                           instr_req_o,
  output logic [riscv_isa_pkg::XLEN-1:0] instr_addr_o,
  output logic                           f_valid_o,
  output logic [riscv_isa_pkg::ILEN-1:0] f_instr_o,
  output logic [riscv_isa_pkg::XLEN-1:0] f_pc_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    S_ISSUE,
    S_WAIT,
    S_DISCARD  // Drop the response of a killed request
  } fetch_state_e;

  fetch_state_e state_q;
  logic [31:0]  pc_q;
  logic         rsp_take;

  // Only ask when the fetch register is empty or drains this cycle
  assign instr_req_o  = !rst_i && (state_q == S_ISSUE) &&
                        (!f_valid_o || !stall_i) && !kill_i;
  assign instr_addr_o = pc_q;
  assign rsp_take     = (state_q == S_WAIT) && instr_rvalid_i && !kill_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_ISSUE;
      pc_q    <= boot_addr_i;
    end else begin
      case (state_q)
        S_ISSUE: begin
          if (instr_req_o) state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (instr_rvalid_i) state_q <= S_ISSUE;
          else if (kill_i)    state_q <= S_DISCARD;
        end
        S_DISCARD: begin
          if (instr_rvalid_i) state_q <= S_ISSUE;
        end
        default: state_q <= S_ISSUE;
      endcase

      if (force_pc_valid_i) pc_q <= force_pc_i;
      else if (rsp_take)    pc_q <= pc_q + PC_STEP;
    end
  end

  ////////////////////
  // Fetch register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i)         f_valid_o <= 1'b0;
    else if (kill_i)   f_valid_o <= 1'b0;
    else if (rsp_take) f_valid_o <= 1'b1;
    else if (!stall_i) f_valid_o <= 1'b0;  // Taken by decode
  end

  always_ff @(posedge clk_i) begin
    if (rsp_take) begin
      f_instr_o <= instr_rdata_i;
      f_pc_o    <= pc_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
/*
 * Pipeline-level definitions of the core.
 * Holds the ALU operation codes passed from decode to execute and the PC step.
 */
`default_nettype none

package core_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // LUI, result is the U immediate
  } alu_op_e;

  // Byte distance between consecutive instructions
  localparam logic [31:0] PC_STEP = 32'd4;

endpackage

`default_nettype wire

/* rtl/riscv_isa_pkg.sv */
/*
 * RV32I encoding constants for the integer subset this core executes.
 * The decoder takes the opcodes and function codes from here, and every
 * module takes its data, instruction and register index widths.
 */
`default_nettype none

package riscv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // Register-register ALU
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3, instr[14:12]
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_SUB = 7'b0100000;  // funct7 of SUB

  // ADDI x0, x0, 0
  localparam logic [ILEN-1:0] INSN_NOP = 32'h0000_0013;

endpackage

`default_nettype wire
